// File: src.f
src/merge_pkg.sv
src/frame_ctrl.sv
src/fifo_ptr_counter.sv
src/input_stage.sv
src/rr_arbiter.sv
src/fifo_storage.sv
src/frame_merger.sv
sim/clk_gen.sv
sim/frame_merger_checker.sv
sim/tb_frame_merger.sv

// File: run_sim.sh
#!/bin/sh
# build and run the frame merger testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_frame_merger -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_frame_merger > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// File: sim/tb_frame_merger.sv
// testbench for the frame merger with stimulus, reference model, comparison, timeout and summary
`timescale 1ns/1ps
`default_nettype none

module tb_frame_merger;

  import merge_pkg::*;

  // --------------------
  // test lengths, timeout
  localparam int LEN_A0 = 12;  // strict alternation frame
  localparam int LEN_A1 = 8;
  localparam int LEN_B0 = 20;  // gaps and stalls
  localparam int LEN_B1 = 15;
  localparam int LEN_C1 = 10;  // input 1 only
  localparam int LEN_D0 = 9;   // frame after the empty one
  localparam int LEN_D1 = 14;
  localparam int TOTAL_BEATS    = LEN_A0 + LEN_A1 + LEN_B0 + LEN_B1 + LEN_C1 + LEN_D0 + LEN_D1;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 200;

  logic        clk;
  logic        nreset;
  logic        proc_req;
  logic        proc_ack;
  frame_cfg_t  frame_cfg;
  logic        in0_valid;
  logic        in0_ready;
  beat_t       in0_beat;
  logic        in1_valid;
  logic        in1_ready;
  beat_t       in1_beat;
  logic        out_valid;
  logic        out_ready;
  fifo_entry_t out_entry;

  logic [31:0] rng_state = 32'd74333;
  int          errors    = 0;
  int          checks    = 0;
  int          cycles    = 0;
  int          stall_pct = 0;     // chance of out_ready low
  logic        alt_mode  = 1'b0;  // expect strict alternation
  logic        cur_en0   = 1'b0;  // input 0 enabled in the current frame
  logic        cur_en1   = 1'b0;  // input 1 enabled in the current frame
  logic        ended0    = 1'b0;  // input 0 has handed over its last beat
  logic        ended1    = 1'b0;
  logic [SRC_WIDTH-1:0] alt_src;  // source expected next in alternation
  beat_t       exp0[$];           // beats still expected per source
  beat_t       exp1[$];
  beat_t       send0[$];          // beats still to send per source
  beat_t       send1[$];

  clk_gen clk_gen_i (
    .clk    (clk),
    .nreset (nreset)
  );

  frame_merger frame_merger_i (
    .clk       (clk),
    .nreset    (nreset),
    .proc_req  (proc_req),
    .proc_ack  (proc_ack),
    .frame_cfg (frame_cfg),
    .in0_valid (in0_valid),
    .in0_ready (in0_ready),
    .in0_beat  (in0_beat),
    .in1_valid (in1_valid),
    .in1_ready (in1_ready),
    .in1_beat  (in1_beat),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_entry (out_entry)
  );

  bind frame_merger frame_merger_checker frame_merger_checker_i (
    .clk       (clk),
    .nreset    (nreset),
    .proc_req  (proc_req),
    .proc_ack  (proc_ack),
    .frame_cfg (frame_cfg),
    .in0_ready (in0_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_entry (out_entry)
  );

  // --------------------
  // random numbers
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = next_rand();
    return (r % 32'd100) < 32'(pct);
  endfunction

  // --------------------
  // reference model
  // one stream beat, last only on the final beat of that stream
  function automatic beat_t make_beat(input logic [DATA_WIDTH-1:0] data, input int idx,
                                      input int len);
    beat_t b;
    b.data = data;
    b.last = (idx == len - 1);
    return b;
  endfunction

  // merged last belongs to the one beat that leaves nothing behind
  function automatic logic is_final_beat(input int left0, input int left1);
    return (left0 + left1) == 1;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // --------------------
  // stimulus
  task automatic set_input(input int src, input logic valid, input beat_t b);
    if (src == 0)
    begin
      in0_valid = valid;
      in0_beat  = b;
    end
    else
    begin
      in1_valid = valid;
      in1_beat  = b;
    end
  endtask

  task automatic drive_stream(input int src, input int gap_pct);
    beat_t b;
    logic  fire;
    while ((src == 0 ? send0.size() : send1.size()) > 0)
    begin
      while (chance(gap_pct))
        @(negedge clk);       // idle gap with valid low
      b = (src == 0) ? send0.pop_front() : send1.pop_front();
      set_input(src, 1'b1, b);
      fire = 1'b0;
      while (!fire)
      begin
        @(posedge clk);
        fire = (src == 0) ? (in0_valid && in0_ready) : (in1_valid && in1_ready);
      end
      @(negedge clk);
      set_input(src, 1'b0, '0);
      if (b.last && src == 0)
        ended0 = 1'b1;        // no more ready until the next frame
      if (b.last && src == 1)
        ended1 = 1'b1;
    end
  endtask

  task automatic run_frame(input logic en0, input logic en1, input int n0, input int n1,
                           input int gap_pct, input int stall, input logic alt);
    logic [31:0] r;
    beat_t       b;
    exp0.delete();
    exp1.delete();
    for (int i = 0; i < n0 && en0; i++)
    begin
      r = next_rand();
      b = make_beat(r[DATA_WIDTH-1:0], i, n0);
      exp0.push_back(b);
      send0.push_back(b);
    end
    for (int i = 0; i < n1 && en1; i++)
    begin
      r = next_rand();
      b = make_beat(r[DATA_WIDTH-1:0], i, n1);
      exp1.push_back(b);
      send1.push_back(b);
    end
    stall_pct = stall;
    alt_mode  = alt;
    alt_src   = '0;  // input 0 wins first
    @(negedge clk);
    cur_en0          = en0;
    cur_en1          = en1;
    ended0           = 1'b0;
    ended1           = 1'b0;
    proc_req         = 1'b1;
    frame_cfg.in0_en = en0;
    frame_cfg.in1_en = en1;
    if (!en0)
      set_input(0, 1'b1, 9'h1a5);  // offered but must never be taken
    fork
      if (en0) drive_stream(0, gap_pct);
      if (en1) drive_stream(1, gap_pct);
    join
    while (!proc_ack)
      @(negedge clk);
    if (!en0)
      set_input(0, 1'b0, '0);
    check("proc_ack beats outstanding", 32'(exp0.size() + exp1.size()), 32'd0);
    repeat (3)
    begin
      @(negedge clk);
      check("proc_ack", 32'(proc_ack), 32'd1);  // held while req high
    end
    proc_req = 1'b0;
    @(negedge clk);
    check("proc_ack", 32'(proc_ack), 32'd0);
  endtask

  // out_ready stalls
  initial
  begin
    out_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      out_ready = !chance(stall_pct);
    end
  end

  // --------------------
  // compare every output transfer with the reference
  initial
  begin : compare
    logic [SRC_WIDTH-1:0] src;
    logic                 exp_last;
    beat_t                exp_b;
    forever
    begin
      @(posedge clk);
      // ready stays low for a disabled or finished stream
      if (nreset && (!cur_en0 || ended0))
        check("in0_ready", 32'(in0_ready), 32'd0);
      if (nreset && (!cur_en1 || ended1))
        check("in1_ready", 32'(in1_ready), 32'd0);
      if (nreset && out_valid && out_ready)
      begin
        src = out_entry.source_id;
        if ((src == 0) ? (exp0.size() == 0) : (exp1.size() == 0))
        begin
          errors++;
          $display("%0t: output beat from source %0d when none was left to send", $time, src);
        end
        else
        begin
          exp_last = is_final_beat(exp0.size(), exp1.size());
          if (alt_mode && exp0.size() > 0 && exp1.size() > 0)
          begin
            check("out_entry.source_id", 32'(src), 32'(alt_src));
            alt_src = ~alt_src;
          end
          exp_b = (src == 0) ? exp0.pop_front() : exp1.pop_front();
          check("out_entry.data", 32'(out_entry.data), 32'(exp_b.data));
          check("out_entry.last", 32'(out_entry.last), 32'(exp_last));
        end
      end
    end
  end

  // run limit
  initial
  begin
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the frames did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("checks %0d errors %0d", checks, errors);
    $display("Some tests failed");
    $finish;
  end

  // --------------------
  // test sequence
  initial
  begin
    proc_req  = 1'b0;
    frame_cfg = '0;
    in0_valid = 1'b0;
    in0_beat  = '0;
    in1_valid = 1'b0;
    in1_beat  = '0;
    wait (nreset === 1'b1);
    @(negedge clk);
    run_frame(1'b1, 1'b1, LEN_A0, LEN_A1, 0, 0, 1'b1);    // strict alternation
    run_frame(1'b1, 1'b1, LEN_B0, LEN_B1, 40, 40, 1'b0);  // gaps and back-pressure
    run_frame(1'b0, 1'b1, 0, LEN_C1, 20, 20, 1'b0);       // input 1 only
    run_frame(1'b0, 1'b0, 0, 0, 0, 0, 1'b0);              // empty frame
    run_frame(1'b1, 1'b1, LEN_D0, LEN_D1, 30, 30, 1'b0);  // next frame runs normally
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/frame_merger_checker.sv
// concurrent assertions on the frame merger ports for output stalls, acknowledge and input 0 enable
`timescale 1ns/1ps
`default_nettype none

module frame_merger_checker (
  input wire                         clk,
  input wire                         nreset,
  input wire                         proc_req,
  input wire                         proc_ack,
  input wire merge_pkg::frame_cfg_t  frame_cfg,
  input wire                         in0_ready,
  input wire                         out_valid,
  input wire                         out_ready,
  input wire merge_pkg::fifo_entry_t out_entry
);

  logic req_q;  // proc_req one cycle back
  logic en0_q;  // in0 enable taken in the first request cycle

  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
    begin
      req_q <= 1'b0;
      en0_q <= 1'b0;
    end
    else
    begin
      req_q <= proc_req;
      if (proc_req && !req_q)
        en0_q <= frame_cfg.in0_en;  // first request cycle
    end
  end

  // --------------------
  // stalled head entry must not move
  stall_stable: assert property (@(posedge clk) disable iff (!nreset)
    (out_valid && !out_ready) |=> $stable(out_entry))
    else $error("out_entry changed while out_valid was high and out_ready low");

  // ack only rises under a pending request
  ack_rise: assert property (@(posedge clk) disable iff (!nreset)
    !(proc_ack && !$past(proc_ack) && !proc_req))
    else $error("proc_ack rose while proc_req was low");

  // disabled input never offers ready
  in0_off: assert property (@(posedge clk) disable iff (!nreset)
    !en0_q |-> !in0_ready)
    else $error("in0_ready high while input 0 is disabled");

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
// testbench clock and reset generator, 4 ns period and reset low for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic nreset
);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial
  begin
    nreset = 1'b0;
    repeat (8) @(negedge clk);
    nreset = 1'b1;          // released away from the rising edge
  end

endmodule

`default_nettype wire

// File: src/frame_merger.sv
// top level of the two input frame merger with its instances and connecting wires
`timescale 1ns/1ps
`default_nettype none

module frame_merger (
  input  wire                        clk,
  input  wire                        nreset,
  // --------------------
  // control
  input  wire                        proc_req,
  output logic                       proc_ack,
  input  wire merge_pkg::frame_cfg_t frame_cfg,
  // --------------------
  // input streams
  input  wire                        in0_valid,
  output logic                       in0_ready,
  input  wire merge_pkg::beat_t      in0_beat,
  input  wire                        in1_valid,
  output logic                       in1_ready,
  input  wire merge_pkg::beat_t      in1_beat,
  // --------------------
  // merged output
  output logic                       out_valid,
  input  wire                        out_ready,
  output merge_pkg::fifo_entry_t     out_entry
);

  import merge_pkg::*;

  logic                 start;        // frame start pulse
  frame_cfg_t           cfg;          // enables latched for the frame
  logic                 hold_valid0;
  logic                 hold_valid1;
  beat_t                hold_beat0;
  beat_t                hold_beat1;
  logic                 done0;
  logic                 done1;
  logic                 take0;
  logic                 take1;
  logic                 we;           // arbiter to fifo write
  fifo_entry_t          wr_entry;
  logic [PTR_WIDTH-1:0] wr_addr;
  logic [PTR_WIDTH-1:0] rd_addr;
  logic                 full;

  frame_ctrl frame_ctrl_i (
    .clk       (clk),
    .nreset    (nreset),
    .proc_req  (proc_req),
    .frame_cfg (frame_cfg),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_last  (out_entry.last),
    .start     (start),
    .cfg       (cfg),
    .proc_ack  (proc_ack)
  );

  input_stage in0_stage (
    .clk        (clk),
    .nreset     (nreset),
    .start      (start),
    .en         (cfg.in0_en),
    .valid      (in0_valid),
    .beat       (in0_beat),
    .take       (take0),
    .ready      (in0_ready),
    .hold_valid (hold_valid0),
    .hold_beat  (hold_beat0),
    .done       (done0)
  );

  input_stage in1_stage (
    .clk        (clk),
    .nreset     (nreset),
    .start      (start),
    .en         (cfg.in1_en),
    .valid      (in1_valid),
    .beat       (in1_beat),
    .take       (take1),
    .ready      (in1_ready),
    .hold_valid (hold_valid1),
    .hold_beat  (hold_beat1),
    .done       (done1)
  );

  rr_arbiter rr_arbiter_i (
    .clk         (clk),
    .nreset      (nreset),
    .start       (start),
    .cfg         (cfg),
    .full        (full),
    .hold_valid0 (hold_valid0),
    .hold_beat0  (hold_beat0),
    .done0       (done0),
    .hold_valid1 (hold_valid1),
    .hold_beat1  (hold_beat1),
    .done1       (done1),
    .take0       (take0),
    .take1       (take1),
    .we          (we),
    .wr_entry    (wr_entry)
  );

  fifo_ptr_counter fifo_ptr_counter_i (
    .clk       (clk),
    .nreset    (nreset),
    .start     (start),
    .we        (we),
    .out_ready (out_ready),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .full      (full),
    .out_valid (out_valid)
  );

  fifo_storage fifo_storage_i (
    .clk      (clk),
    .nreset   (nreset),
    .we       (we),
    .wr_addr  (wr_addr),
    .wr_entry (wr_entry),
    .rd_addr  (rd_addr),
    .rd_entry (out_entry)
  );

endmodule

`default_nettype wire

// File: src/fifo_storage.sv
// fifo entry array with write port at wr_addr and combinational read at rd_addr
`timescale 1ns/1ps
`default_nettype none

module fifo_storage (
  input  wire                             clk,
  input  wire                             nreset,
  input  wire                             we,
  input  wire [merge_pkg::PTR_WIDTH-1:0]  wr_addr,
  input  wire merge_pkg::fifo_entry_t     wr_entry,
  input  wire [merge_pkg::PTR_WIDTH-1:0]  rd_addr,
  output merge_pkg::fifo_entry_t          rd_entry
);

  import merge_pkg::*;

  fifo_entry_t mem [FIFO_DEPTH];  // entry array

  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
    begin
      for (int i = 0; i < FIFO_DEPTH; i++)
        mem[i] <= '0;
    end
    else if (we)
      mem[wr_addr] <= wr_entry;  // visible at the read port next cycle
  end

  // head of the fifo straight to the output
  assign rd_entry = mem[rd_addr];

endmodule

`default_nettype wire

// File: src/rr_arbiter.sv
// round robin choice between the two held beats, merged last flag and fifo write
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter (
  input  wire                        clk,
  input  wire                        nreset,
  input  wire                        start,        // frame start, input 0 wins first
  input  wire merge_pkg::frame_cfg_t cfg,
  input  wire                        full,         // fifo cannot take a write
  input  wire                        hold_valid0,
  input  wire merge_pkg::beat_t      hold_beat0,
  input  wire                        done0,
  input  wire                        hold_valid1,
  input  wire merge_pkg::beat_t      hold_beat1,
  input  wire                        done1,
  output logic                       take0,
  output logic                       take1,
  output logic                       we,
  output merge_pkg::fifo_entry_t     wr_entry
);

  import merge_pkg::*;

  logic [SRC_WIDTH-1:0] last_src;    // source granted most recently
  logic [SRC_WIDTH-1:0] grant_src;   // source granted this cycle
  logic                 prefer0;     // input 0 has priority this cycle
  logic                 drained0;    // input 0 has nothing left after this cycle
  logic                 drained1;
  logic                 frame_last;  // written beat closes the merged frame

  // --------------------
  // grant
  assign prefer0 = (last_src == SRC_WIDTH'(1));
  assign take0   = !full && hold_valid0 && (prefer0 || !hold_valid1);
  assign take1   = !full && hold_valid1 && (!prefer0 || !hold_valid0);
  assign we      = take0 || take1;

  assign grant_src = take0 ? SRC_WIDTH'(0) : SRC_WIDTH'(1);

  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
      last_src <= SRC_WIDTH'(1);
    else if (start)
      last_src <= SRC_WIDTH'(1);
    else if (we)
      last_src <= grant_src;
  end

  // --------------------
  // merged last
  // disabled inputs count as drained
  assign drained0   = !cfg.in0_en || (done0 && (!hold_valid0 || take0));
  assign drained1   = !cfg.in1_en || (done1 && (!hold_valid1 || take1));
  assign frame_last = drained0 && drained1;

  always_comb
  begin
    wr_entry.data      = take0 ? hold_beat0.data : hold_beat1.data;
    wr_entry.last      = frame_last;  // per-stream last flags never pass through
    wr_entry.source_id = grant_src;
  end

endmodule

`default_nettype wire

// File: src/input_stage.sv
// one input stream stage with holding register, ready logic and end of stream flag
`timescale 1ns/1ps
`default_nettype none

module input_stage (
  input  wire                   clk,
  input  wire                   nreset,
  input  wire                   start,       // frame start
  input  wire                   en,          // stream takes part in this frame
  input  wire                   valid,
  input  wire merge_pkg::beat_t beat,
  input  wire                   take,        // arbiter moves the held beat out
  output logic                  ready,
  output logic                  hold_valid,  // holding register occupied
  output merge_pkg::beat_t      hold_beat,
  output logic                  done         // last beat already accepted
);

  logic accept;  // input transfer this cycle

  // a take frees the register in the same cycle so streaming has no bubble
  assign ready  = en && !start && !done && (!hold_valid || take);
  assign accept = valid && ready;

  // --------------------
  // control flags
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
    begin
      hold_valid <= 1'b0;
      done       <= 1'b0;
    end
    else if (start)
    begin
      hold_valid <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      if (accept)
        hold_valid <= 1'b1;  // refill wins over take
      else if (take)
        hold_valid <= 1'b0;
      if (accept && beat.last)
        done <= 1'b1;        // blocks the stream until next frame
    end
  end

  // payload
  always_ff @(posedge clk)
  begin
    if (accept)
      hold_beat <= beat;
  end

endmodule

`default_nettype wire

// File: src/fifo_ptr_counter.sv
// fifo write and read pointers with wrap bit, fill level, full and output valid
`timescale 1ns/1ps
`default_nettype none

module fifo_ptr_counter (
  input  wire                            clk,
  input  wire                            nreset,
  input  wire                            start,      // frame start empties the fifo
  input  wire                            we,         // arbiter writes one entry
  input  wire                            out_ready,
  output logic [merge_pkg::PTR_WIDTH-1:0] wr_addr,
  output logic [merge_pkg::PTR_WIDTH-1:0] rd_addr,
  output logic                            full,
  output logic                            out_valid
);

  import merge_pkg::*;

  logic [PTR_WIDTH:0] wr_ptr;  // msb is the wrap bit
  logic [PTR_WIDTH:0] rd_ptr;
  logic [PTR_WIDTH:0] level;   // occupied entries 0 to FIFO_DEPTH
  logic               empty;
  logic               rd;      // head entry leaves this cycle

  assign rd = out_valid && out_ready;

  // --------------------
  // pointers
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else if (start)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (we)
        wr_ptr <= wr_ptr + (PTR_WIDTH+1)'(1);  // power of two depth wraps on its own
      if (rd)
        rd_ptr <= rd_ptr + (PTR_WIDTH+1)'(1);
    end
  end

  // --------------------
  // level and flags
  assign level = wr_ptr - rd_ptr;
  assign full  = (level == (PTR_WIDTH+1)'(FIFO_DEPTH));
  assign empty = (level == '0);

  assign out_valid = !empty;
  assign wr_addr   = wr_ptr[PTR_WIDTH-1:0];
  assign rd_addr   = rd_ptr[PTR_WIDTH-1:0];

endmodule

`default_nettype wire

// File: src/frame_ctrl.sv
// frame control fsm for request, start, run and acknowledge, with the frame config register
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl (
  input  wire                        clk,
  input  wire                        nreset,
  input  wire                        proc_req,   // frame request
  input  wire merge_pkg::frame_cfg_t frame_cfg,  // enables offered with the request
  input  wire                        out_valid,
  input  wire                        out_ready,
  input  wire                        out_last,   // last flag of the entry at the fifo head
  output logic                       start,      // one cycle pulse that clears the datapath
  output merge_pkg::frame_cfg_t      cfg,        // enables held for the whole frame
  output logic                       proc_ack
);

  import merge_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        frame_end;  // merged final beat leaves this cycle
  logic        no_inputs;  // empty frame completes without any beat

  assign frame_end = out_valid && out_ready && out_last;
  assign no_inputs = !cfg.in0_en && !cfg.in1_en;

  // --------------------
  // next state
  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (proc_req)
          state_nxt = ST_START;
      ST_START:
        state_nxt = ST_RUN;  // always a single cycle
      ST_RUN:
        if (frame_end || no_inputs)
          state_nxt = ST_ACK;
      ST_ACK:
        if (!proc_req)
          state_nxt = ST_IDLE;  // ack falls one cycle after req
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  // --------------------
  // state and config registers
  always_ff @(posedge clk or negedge nreset)
  begin
    if (!nreset)
    begin
      state <= ST_IDLE;
      cfg   <= '0;
    end
    else
    begin
      state <= state_nxt;
      if (state == ST_IDLE && proc_req)
        cfg <= frame_cfg;  // taken in the first request cycle only
    end
  end

  assign start    = (state == ST_START);
  assign proc_ack = (state == ST_ACK);

endmodule

`default_nettype wire

// File: src/merge_pkg.sv
// sizes, frame controller state enum and packed beat, fifo entry and frame config types
`default_nettype none

package merge_pkg;

  // --------------------
  // sizes
  localparam int DATA_WIDTH = 8;                   // bits per data beat
  localparam int FIFO_DEPTH = 4;                   // merged fifo entries
  localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);  // fifo address bits
  localparam int NUM_INPUTS = 2;                   // merged input streams
  localparam int SRC_WIDTH  = $clog2(NUM_INPUTS);  // bits of a source id

  // --------------------
  // frame controller states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,  // waiting for proc_req
    ST_START = 2'd1,  // one cycle of per-frame clearing
    ST_RUN   = 2'd2,  // beats flow until the final one leaves
    ST_ACK   = 2'd3   // proc_ack held until proc_req drops
  } ctrl_state_t;

  // --------------------
  // payload types
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;  // final beat of this stream in the frame
  } beat_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;       // final beat of the whole merged frame
    logic [SRC_WIDTH-1:0]  source_id;  // input the beat came from
  } fifo_entry_t;

  typedef struct packed {
    logic in0_en;  // input 0 takes part
    logic in1_en;  // input 1 takes part
  } frame_cfg_t;

endpackage

`default_nettype wire
